//--- source/axi_rd_pkg.sv
package axi_rd_pkg;

    ////////////////////
    // Channel widths
    ////////////////////
    localparam int AXI_ID_W    = 4;
    localparam int AXI_ADDR_W  = 29;  // Word address
    localparam int AXI_LEN_W   = 8;
    localparam int AXI_DATA_W  = 64;
    localparam int AXI_SIZE_W  = 3;
    localparam int AXI_BURST_W = 2;

    typedef logic [AXI_ID_W-1:0]    axi_id_t;
    typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [AXI_LEN_W-1:0]   axi_len_t;   // Beats minus one
    typedef logic [AXI_DATA_W-1:0]  axi_data_t;
    typedef logic [AXI_SIZE_W-1:0]  axi_size_t;
    typedef logic [AXI_BURST_W-1:0] axi_burst_t;

    ////////////////////
    // Fixed burst encodings
    ////////////////////
    localparam axi_size_t  AXI_SIZE_8B    = 3'd3;  // 8 bytes per beat
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;  // Incrementing

    // Read address channel payload, 46 bits
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ar_t;

    // Read data channel payload, response code not carried
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        logic      last;
    } axi_r_t;

endpackage

//--- source/rd_bridge_pkg.sv
package rd_bridge_pkg;

    ////////////////////
    // Bridge sizing
    ////////////////////
    localparam int NUM_CLIENTS = 4;
    localparam int CLIENT_W    = 2;   // Index width for NUM_CLIENTS
    localparam int NUM_TAGS    = 16;  // One entry per ID value

    typedef logic [CLIENT_W-1:0]    client_idx_t;
    typedef logic [NUM_CLIENTS-1:0] client_vec_t;  // One bit per client

    // Client burst request, 41 bits
    typedef struct packed {
        axi_rd_pkg::axi_id_t   id;
        axi_rd_pkg::axi_addr_t addr;
        axi_rd_pkg::axi_len_t  len;
    } rd_req_t;

    // Per-client progress
    typedef enum logic [1:0] {
        SLOT_IDLE      = 2'd0,  // Free for a new request
        SLOT_PENDING   = 2'd1,  // Waiting for the AR channel
        SLOT_IN_FLIGHT = 2'd2   // Address sent, beats outstanding
    } slot_state_t;

endpackage

//--- source/rd_client_slot.sv
`timescale 1ns/1ps

module rd_client_slot (
    input  logic                   clk,
    input  logic                   rst,
    // Client request side
    input  logic                   req,
    input  rd_bridge_pkg::rd_req_t req_data,
    output logic                   req_ack,
    output logic                   in_prog,
    // Toward arbiter and router
    input  logic                   issued,     // AR handshake for this slot
    input  logic                   done,       // Last beat transferred
    output logic                   pending,
    output rd_bridge_pkg::rd_req_t pend_req
);

    rd_bridge_pkg::slot_state_t state;
    rd_bridge_pkg::slot_state_t state_nxt;

    ////////////////////
    // Handshake
    ////////////////////
    // Accept only when free, same cycle as req
    assign req_ack = req && (state == rd_bridge_pkg::SLOT_IDLE);

    assign pending = (state == rd_bridge_pkg::SLOT_PENDING);
    assign in_prog = (state != rd_bridge_pkg::SLOT_IDLE);  // Both busy states

    ////////////////////
    // Progress FSM
    ////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            rd_bridge_pkg::SLOT_IDLE: begin
                if (req) state_nxt = rd_bridge_pkg::SLOT_PENDING;  // Captured now
            end
            rd_bridge_pkg::SLOT_PENDING: begin
                if (issued) state_nxt = rd_bridge_pkg::SLOT_IN_FLIGHT;
            end
            rd_bridge_pkg::SLOT_IN_FLIGHT: begin
                // Back to idle after last beat, in_prog drops next cycle
                if (done) state_nxt = rd_bridge_pkg::SLOT_IDLE;
            end
            default: state_nxt = rd_bridge_pkg::SLOT_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= rd_bridge_pkg::SLOT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request held until arbiter takes it
    always_ff @(posedge clk) begin
        if (req_ack) begin
            pend_req <= req_data;
        end
    end

endmodule

//--- source/rd_addr_arbiter.sv
`timescale 1ns/1ps

module rd_addr_arbiter (
    input  logic                       clk,
    input  logic                       rst,
    // From slots
    input  rd_bridge_pkg::client_vec_t pending,
    input  rd_bridge_pkg::rd_req_t     pend_reqs [rd_bridge_pkg::NUM_CLIENTS],
    output rd_bridge_pkg::client_vec_t issued,     // One-hot on handshake
    // AXI read address channel
    output axi_rd_pkg::axi_ar_t        ar,
    output logic                       arvalid,
    input  logic                       arready,
    // Toward tag table
    output logic                       ar_fire,
    output rd_bridge_pkg::client_idx_t grant_idx
);

    rd_bridge_pkg::client_idx_t rr_ptr;  // Last granted client
    rd_bridge_pkg::client_idx_t cand;
    rd_bridge_pkg::client_idx_t pick;
    logic                       found;
    rd_bridge_pkg::rd_req_t     req_q;   // Granted request

    assign ar_fire = arvalid && arready;

    ////////////////////
    // Round-robin search
    ////////////////////
    // First pending slot after rr_ptr, rr_ptr itself checked last
    always_comb begin
        found = 1'b0;
        pick  = rr_ptr;
        cand  = rr_ptr;
        for (int k = 1; k <= rd_bridge_pkg::NUM_CLIENTS; k++) begin
            cand = rd_bridge_pkg::client_idx_t'((int'(rr_ptr) + k) % rd_bridge_pkg::NUM_CLIENTS);
            if (!found && pending[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // Grant and arvalid on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            rr_ptr  <= rd_bridge_pkg::client_idx_t'(rd_bridge_pkg::NUM_CLIENTS - 1);
        end else if (ar_fire) begin
            arvalid <= 1'b0;       // One idle cycle, slot clear settles
            rr_ptr  <= grant_idx;  // Advance past winner
        end else if (!arvalid && found) begin
            arvalid <= 1'b1;
        end
    end

    // Fields frozen while arvalid is up
    always_ff @(posedge clk) begin
        if (!arvalid && found) begin
            grant_idx <= pick;
            req_q     <= pend_reqs[pick];
        end
    end

    ////////////////////
    // AR channel drive
    ////////////////////
    assign ar.id    = req_q.id;
    assign ar.addr  = req_q.addr;
    assign ar.len   = req_q.len;
    assign ar.size  = axi_rd_pkg::AXI_SIZE_8B;     // Full 64-bit beats
    assign ar.burst = axi_rd_pkg::AXI_BURST_INCR;

    // Tell the winning slot its address went out
    always_comb begin
        issued = '0;
        if (ar_fire) issued[grant_idx] = 1'b1;
    end

endmodule

//--- source/rd_return_router.sv
`timescale 1ns/1ps

module rd_return_router (
    input  logic                       clk,
    input  logic                       rst,
    // Table write from AR handshake
    input  logic                       ar_fire,
    input  axi_rd_pkg::axi_id_t        ar_id,
    input  rd_bridge_pkg::client_idx_t grant_idx,
    // AXI read data channel
    input  axi_rd_pkg::axi_r_t         r,
    input  logic                       rvalid,
    output logic                       rready,
    // Client data side
    input  rd_bridge_pkg::client_vec_t data_rdy,
    output rd_bridge_pkg::client_vec_t data_vld,
    output axi_rd_pkg::axi_data_t      data,       // Shared by all clients
    output rd_bridge_pkg::client_vec_t cmpl,
    // Toward slots
    output rd_bridge_pkg::client_vec_t done
);

    ////////////////////
    // Tag lookaside table
    ////////////////////
    logic [rd_bridge_pkg::NUM_TAGS-1:0] tag_vld;                          // ID outstanding
    rd_bridge_pkg::client_idx_t         tag_own [rd_bridge_pkg::NUM_TAGS]; // Owning client

    logic                       hit;
    rd_bridge_pkg::client_idx_t owner;
    logic                       last_fire;

    // Lookup by response ID
    assign hit   = tag_vld[r.id];
    assign owner = tag_own[r.id];

    ////////////////////
    // Beat steering
    ////////////////////
    // Unknown ID drains with rready high
    assign rready = hit ? data_rdy[owner] : 1'b1;
    assign data   = r.data;

    always_comb begin
        data_vld = '0;
        if (rvalid && hit) data_vld[owner] = 1'b1;
    end

    // Strobe only on the transfer of the last beat
    assign cmpl      = data_vld & data_rdy & {rd_bridge_pkg::NUM_CLIENTS{r.last}};
    assign done      = cmpl;  // Same strobe, slot side
    assign last_fire = rvalid && rready && hit && r.last;

    // Entries set on AR handshake, dropped on last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < rd_bridge_pkg::NUM_TAGS; t++) begin
                tag_vld[t] <= 1'b0;
                tag_own[t] <= '0;
            end
        end else begin
            if (last_fire) begin
                tag_vld[r.id] <= 1'b0;
            end
            if (ar_fire) begin  // New issue wins over clear
                tag_vld[ar_id] <= 1'b1;
                tag_own[ar_id] <= grant_idx;
            end
        end
    end

endmodule

//--- source/rd_bridge_top.sv
`timescale 1ns/1ps

module rd_bridge_top (
    input  logic                       clk,
    input  logic                       rst,
    // Client request ports
    input  rd_bridge_pkg::client_vec_t req,
    input  rd_bridge_pkg::rd_req_t     req_data [rd_bridge_pkg::NUM_CLIENTS],
    output rd_bridge_pkg::client_vec_t req_ack,
    output rd_bridge_pkg::client_vec_t in_prog,
    // Client data ports
    output rd_bridge_pkg::client_vec_t data_vld,
    output axi_rd_pkg::axi_data_t      data,
    input  rd_bridge_pkg::client_vec_t data_rdy,
    output rd_bridge_pkg::client_vec_t cmpl,
    // AXI4 read address channel
    output axi_rd_pkg::axi_ar_t        ar,
    output logic                       arvalid,
    input  logic                       arready,
    // AXI4 read data channel
    input  axi_rd_pkg::axi_r_t         r,
    input  logic                       rvalid,
    output logic                       rready
);

    rd_bridge_pkg::client_vec_t pending;
    rd_bridge_pkg::client_vec_t issued;
    rd_bridge_pkg::client_vec_t done;
    rd_bridge_pkg::rd_req_t     pend_reqs [rd_bridge_pkg::NUM_CLIENTS];
    logic                       ar_fire;
    rd_bridge_pkg::client_idx_t grant_idx;

    ////////////////////
    // Client slots
    ////////////////////
    for (genvar g = 0; g < rd_bridge_pkg::NUM_CLIENTS; g++) begin : g_slot
        rd_client_slot u_slot (
            .clk      (clk),
            .rst      (rst),
            .req      (req[g]),
            .req_data (req_data[g]),
            .req_ack  (req_ack[g]),
            .in_prog  (in_prog[g]),
            .issued   (issued[g]),
            .done     (done[g]),
            .pending  (pending[g]),
            .pend_req (pend_reqs[g])
        );
    end

    // Pending slots onto AR
    rd_addr_arbiter u_arb (
        .clk       (clk),
        .rst       (rst),
        .pending   (pending),
        .pend_reqs (pend_reqs),
        .issued    (issued),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .ar_fire   (ar_fire),
        .grant_idx (grant_idx)
    );

    // Beats back to owners by ID
    rd_return_router u_rtr (
        .clk       (clk),
        .rst       (rst),
        .ar_fire   (ar_fire),
        .ar_id     (ar.id),
        .grant_idx (grant_idx),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .data_rdy  (data_rdy),
        .data_vld  (data_vld),
        .data      (data),
        .cmpl      (cmpl),
        .done      (done)
    );

endmodule

//--- verification/rd_bridge_chk.sv
`timescale 1ns/1ps

module rd_bridge_chk (
    input logic                       clk,
    input logic                       rst,
    input axi_rd_pkg::axi_ar_t        ar,
    input logic                       arvalid,
    input logic                       arready,
    input rd_bridge_pkg::client_vec_t req_ack,
    input rd_bridge_pkg::client_vec_t in_prog,
    input rd_bridge_pkg::client_vec_t data_vld,
    input rd_bridge_pkg::client_vec_t cmpl
);

    int fail_cnt = 0;  // Failed assertions so far

    ////////////////////
    // AR channel
    ////////////////////
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar))
        else begin
            $error("AR payload or arvalid changed before arready");
            fail_cnt++;
        end

    ////////////////////
    // R channel steering
    ////////////////////
    // Beats only toward a client with a burst out
    vld_busy: assert property (@(posedge clk) disable iff (rst)
        (data_vld & ~in_prog) == '0)
        else begin
            $error("data_vld raised for a client with no burst in progress");
            fail_cnt++;
        end

    // Slot released right after its last beat
    cmpl_release: assert property (@(posedge clk) disable iff (rst)
        cmpl != '0 |=> ($past(cmpl) & in_prog) == '0)
        else begin
            $error("in_prog still high in the cycle after cmpl");
            fail_cnt++;
        end

    rst_quiet: assert property (@(posedge clk)
        $fell(rst) |-> !arvalid && ((req_ack | in_prog | data_vld | cmpl) == '0))
        else begin
            $error("Output high in the first cycle out of reset");
            fail_cnt++;
        end

endmodule

bind rd_bridge_top rd_bridge_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .ar       (ar),
    .arvalid  (arvalid),
    .arready  (arready),
    .req_ack  (req_ack),
    .in_prog  (in_prog),
    .data_vld (data_vld),
    .cmpl     (cmpl)
);

//--- verification/rd_bridge_tb.sv
`timescale 1ns/1ps

module rd_bridge_tb;

    localparam int NC         = rd_bridge_pkg::NUM_CLIENTS;
    localparam int REQS       = 12;               // Requests per client
    localparam int TOTAL      = NC * REQS;
    localparam int TIMEOUT_NS = TOTAL * 60 * 40;  // 60 cycles per request

    // Outstanding burst in the slave model
    typedef struct packed {
        rd_bridge_pkg::rd_req_t req;
        axi_rd_pkg::axi_len_t   beat;  // Next beat to return
    } burst_t;

    logic                       clk;
    logic                       rst;
    rd_bridge_pkg::client_vec_t req, req_ack, in_prog, data_vld, data_rdy, cmpl;
    rd_bridge_pkg::rd_req_t     req_data [NC];
    axi_rd_pkg::axi_data_t      data;
    axi_rd_pkg::axi_ar_t        ar;
    axi_rd_pkg::axi_r_t         r;
    logic                       arvalid, arready, rvalid, rready;

    rd_bridge_pkg::client_vec_t busy;         // Acknowledged, not yet complete
    rd_bridge_pkg::client_vec_t issued_m;     // Address already sent
    rd_bridge_pkg::client_vec_t passed [NC];  // Who went first while this client waited
    rd_bridge_pkg::rd_req_t     cur [NC];
    int                         sent [NC];
    int                         beat [NC];
    int                         done_total, err_cnt, misc_cnt;
    burst_t                     bursts [$];
    int                         cur_b;        // Burst on the R channel
    logic                       beat_taken;

    rd_bridge_top uut (.*);

    always #20 clk = ~clk;

    task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    // Beat k holds addr+k in both halves
    function automatic axi_rd_pkg::axi_data_t beat_word(axi_rd_pkg::axi_addr_t addr, int k);
        logic [31:0] w;
        w = 32'(addr) + 32'(k);
        return {w, w};
    endfunction

    function automatic int id_owner(axi_rd_pkg::axi_id_t id);
        return int'(id) / 4;  // Four IDs per client
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic drive_inputs();
        for (int c = 0; c < NC; c++) begin
            if (busy[c]) req[c] = 1'b0;  // Taken at the last edge
            if (!req[c] && !busy[c] && sent[c] < REQS && $urandom_range(0, 1) == 1) begin
                req[c]           = 1'b1;
                req_data[c].id   = axi_rd_pkg::axi_id_t'(c * 4 + $urandom_range(0, 3));
                req_data[c].addr = axi_rd_pkg::axi_addr_t'($urandom);
                req_data[c].len  = axi_rd_pkg::axi_len_t'($urandom_range(0, 7));
            end
            data_rdy[c] = ($urandom_range(0, 3) != 0);
        end
        arready = ($urandom_range(0, 2) != 0);
        // Beat held until taken, then any burst may go next
        if (beat_taken || !rvalid) begin
            rvalid     = 1'b0;
            beat_taken = 1'b0;
            if (bursts.size() > 0 && $urandom_range(0, 2) != 0) begin
                cur_b  = $urandom_range(0, bursts.size() - 1);
                rvalid = 1'b1;
                r.id   = bursts[cur_b].req.id;
                r.data = beat_word(bursts[cur_b].req.addr, int'(bursts[cur_b].beat));
                r.last = (bursts[cur_b].beat == bursts[cur_b].req.len);
            end
        end
    endtask

    ////////////////////
    // Scoreboard
    ////////////////////
    task automatic check_ar();
        burst_t nb;
        int     g;
        g = id_owner(ar.id);
        if (!busy[g] || issued_m[g]) begin
            misc_cnt++;
            $display("AR at %0t with ID %0h matches no waiting request", $time, ar.id);
        end else begin
            check_val("ar.id", cur[g].id, ar.id);
            check_val("ar.addr", cur[g].addr, ar.addr);
            check_val("ar.len", cur[g].len, ar.len);
            check_val("ar.size", 3, ar.size);    // 8-byte beats
            check_val("ar.burst", 1, ar.burst);  // INCR
            for (int p = 0; p < NC; p++) begin
                if (p != g && busy[p] && !issued_m[p]) begin
                    if (passed[p][g]) begin
                        misc_cnt++;
                        $display("At %0t client %0d was issued twice while client %0d waited",
                                 $time, g, p);
                    end
                    passed[p][g] = 1'b1;
                end
            end
            passed[g]   = '0;
            issued_m[g] = 1'b1;
        end
        nb.req.id   = ar.id;
        nb.req.addr = ar.addr;
        nb.req.len  = ar.len;
        nb.beat     = '0;
        bursts.push_back(nb);
    endtask

    task automatic sample_cycle();
        rd_bridge_pkg::client_vec_t exp_vld;
        rd_bridge_pkg::client_vec_t acc;
        exp_vld = '0;
        acc     = req & ~busy;
        if (rvalid) exp_vld[id_owner(r.id)] = 1'b1;
        for (int c = 0; c < NC; c++) begin
            check_val($sformatf("req_ack[%0d]", c), acc[c], req_ack[c]);
            check_val($sformatf("in_prog[%0d]", c), busy[c], in_prog[c]);
            check_val($sformatf("data_vld[%0d]", c), exp_vld[c], data_vld[c]);
            check_val($sformatf("cmpl[%0d]", c),
                      exp_vld[c] && data_rdy[c] && (beat[c] == int'(cur[c].len)), cmpl[c]);
        end
        if (rvalid) check_val("rready", data_rdy[id_owner(r.id)], rready);
        if (arvalid && arready) check_ar();
        for (int c = 0; c < NC; c++) begin
            if (exp_vld[c] && data_rdy[c]) begin
                check_val($sformatf("data[%0d]", c), beat_word(cur[c].addr, beat[c]), data);
                if (beat[c] == int'(cur[c].len)) begin
                    busy[c] = 1'b0;
                    done_total++;
                end else begin
                    beat[c]++;
                end
            end
            if (acc[c]) begin  // Captured at the coming edge
                busy[c]     = 1'b1;
                issued_m[c] = 1'b0;
                cur[c]      = req_data[c];
                beat[c]     = 0;
                sent[c]++;
            end
        end
        if (rvalid && rready) begin
            beat_taken = 1'b1;
            if (r.last) bursts.delete(cur_b);
            else bursts[cur_b].beat = bursts[cur_b].beat + 1'b1;
        end
    endtask

    initial begin
        void'($urandom(78821));
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        data_rdy   = '0;
        arready    = 1'b0;
        rvalid     = 1'b0;
        r          = '0;
        busy       = '0;
        issued_m   = '0;
        done_total = 0;
        err_cnt    = 0;
        misc_cnt   = 0;
        cur_b      = 0;
        beat_taken = 1'b0;
        for (int c = 0; c < NC; c++) begin
            req_data[c] = '0;
            cur[c]      = '0;
            passed[c]   = '0;
            sent[c]     = 0;
            beat[c]     = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        // Quiet outputs out of reset
        check_val("req_ack", 0, req_ack);
        check_val("in_prog", 0, in_prog);
        check_val("data_vld", 0, data_vld);
        check_val("cmpl", 0, cmpl);
        check_val("arvalid", 0, arvalid);
        rst = 1'b0;
        while (done_total < TOTAL) begin
            @(posedge clk);
            #1;
            drive_inputs();
            #30;  // Settled, ahead of the next edge
            sample_cycle();
        end
        @(posedge clk);
        #1;
        rvalid = 1'b0;
        repeat (3) @(posedge clk);
        misc_cnt += uut.u_chk.fail_cnt;
        $display("Requests done %0d of %0d, value errors %0d, other errors %0d",
                 done_total, TOTAL, err_cnt, misc_cnt);
        if (err_cnt == 0 && misc_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns with %0d of %0d requests complete",
                 TIMEOUT_NS, done_total, TOTAL);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- project.f
source/axi_rd_pkg.sv
source/rd_bridge_pkg.sv
source/rd_client_slot.sv
source/rd_addr_arbiter.sv
source/rd_return_router.sv
source/rd_bridge_top.sv
verification/rd_bridge_chk.sv
verification/rd_bridge_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the read bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rd_bridge_tb -f project.f -o rd_bridge_sim

./obj_dir/rd_bridge_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
